/* verilog/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Backing RAM geometry.
`define MEM_SIZE_BYTES 512
`define ADDR_WIDTH 9

// Memory bus line geometry.
`define LINE_BYTES 16
`define LINE_OFFSET_BITS 4
`define LINE_BITS (`LINE_BYTES * 8)
`define LINE_ADDR_WIDTH (`ADDR_WIDTH - `LINE_OFFSET_BITS)

// Client word geometry.
`define WORD_BYTES 4
`define WORD_OFFSET_BITS 2
`define WORD_BITS (`WORD_BYTES * 8)

// Number of word ports sharing the memory bus.
`define NUM_PORTS 2

`endif

/* verilog/mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

  // word request from a client port, held stable while req is high.
  typedef struct packed {
    logic                        write; // high for a store.
    logic [`ADDR_WIDTH-1:0]      addr;  // byte address, word aligned.
    logic [`WORD_BITS-1:0]       wdata; // store data, byte 0 in the low bits.
    logic [`WORD_BYTES-1:0]      mask;  // one enable per byte of wdata.
  } word_req_t;

  // word response, valid while ack is high.
  typedef struct packed {
    logic [`WORD_BITS-1:0] rdata; // loaded word, or the merged word after a store.
  } word_rsp_t;

  // Command on the shared line-wide memory bus.
  typedef struct packed {
    logic                        read;      // one-cycle read strobe.
    logic                        write;     // one-cycle write strobe.
    logic [`LINE_ADDR_WIDTH-1:0] line_addr; // line index into the RAM.
    logic [`LINE_BITS-1:0]       data;      // full line for a write.
  } line_cmd_t;

endpackage

/* verilog/line_ram.sv */
`include "mem_params.svh"

module line_ram
  import mem_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  line_cmd_t             cmd,
  output logic                  ready,
  output logic                  done,
  output logic [`LINE_BITS-1:0] rdata
);

  logic [7:0]             mem [`MEM_SIZE_BYTES]; // byte storage, undefined until written.
  logic [`ADDR_WIDTH-1:0] base;                  // first byte of the addressed line.

  assign base = {cmd.line_addr, {`LINE_OFFSET_BITS{1'b0}}}; // lines are always aligned.

  // Storage and read data path.
  // Byte i of a line sits in bits [8*i +: 8] on the bus, so the lowest address
  // lands in the low byte just as it does for words.
  always_ff @(posedge clock) begin
    if (cmd.read) begin
      for (int i = 0; i < `LINE_BYTES; i++) begin
        rdata[8*i +: 8] <= mem[base + `ADDR_WIDTH'(i)];
      end
    end
    if (cmd.write) begin
      for (int i = 0; i < `LINE_BYTES; i++) begin
        mem[base + `ADDR_WIDTH'(i)] <= cmd.data[8*i +: 8];
      end
    end
  end

  // Handshake pulses follow their strobe by exactly one cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
      done  <= 1'b0;
    end else begin
      ready <= cmd.read;  // rdata is valid in the same cycle.
      done  <= cmd.write; // the line is stored by now.
    end
  end

  // The arbiter and the word ports together must keep the strobes apart.
  property p_no_read_write_overlap;
    @(posedge clock) disable iff (reset)
      !(cmd.read && cmd.write);
  endproperty

  assert property (p_no_read_write_overlap)
    else $error("line_ram: read and write strobes high together");

  // Strobes are single-cycle pulses, and a new one waits for ready or done.
  property p_read_is_pulse;
    @(posedge clock) disable iff (reset)
      cmd.read |=> !cmd.read;
  endproperty

  property p_write_is_pulse;
    @(posedge clock) disable iff (reset)
      cmd.write |=> !cmd.write;
  endproperty

  assert property (p_read_is_pulse)
    else $error("line_ram: read strobe held for two cycles");

  assert property (p_write_is_pulse)
    else $error("line_ram: write strobe held for two cycles");

endmodule

/* verilog/bus_arbiter.sv */
`include "mem_params.svh"

module bus_arbiter
  import mem_pkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  logic      [`NUM_PORTS-1:0]  busy,
  input  line_cmd_t [`NUM_PORTS-1:0]  port_cmd,
  output logic      [`NUM_PORTS-1:0]  grant,
  output line_cmd_t                   cmd
);

  logic [`NUM_PORTS-1:0] grant_q;    // registered owner of the bus.
  logic [`NUM_PORTS-1:0] grant_next;
  logic                  prio_q;     // port that wins a tie, 0 is fetch.
  logic                  prio_next;

  // The grant drops in the same cycle the owner lets go of busy.
  // That frees the bus one cycle before the owner's ack falls.
  assign grant = grant_q & busy;

  // Next owner selection.
  // An owner keeps the bus for as long as busy stays high, which covers the
  // whole read-modify-write and any time the client sits on its ack.
  always_comb begin
    grant_next = grant_q & busy; // hold the current owner.
    prio_next  = prio_q;
    if (grant_next == '0) begin
      if (busy[prio_q]) begin
        grant_next[prio_q] = 1'b1;
        prio_next          = ~prio_q; // the other port goes first next time.
      end else if (busy[~prio_q]) begin
        grant_next[~prio_q] = 1'b1;
        prio_next           = prio_q; // the favoured port keeps its claim.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      grant_q <= '0;
      prio_q  <= 1'b0; // fetch is favoured out of reset.
    end else begin
      grant_q <= grant_next;
      prio_q  <= prio_next;
    end
  end

  // Only the owner's command reaches the RAM; the bus is quiet otherwise.
  always_comb begin
    cmd = '0;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (grant[p]) begin
        cmd = port_cmd[p];
      end
    end
  end

  property p_grant_onehot;
    @(posedge clock) disable iff (reset)
      $onehot0(grant);
  endproperty

  assert property (p_grant_onehot)
    else $error("bus_arbiter: more than one port granted");

endmodule

/* verilog/word_port.sv */
`include "mem_params.svh"

module word_port
  import mem_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req,
  input  word_req_t             req_data,
  output logic                  ack,
  output word_rsp_t             rsp,
  output logic                  busy,
  input  logic                  granted,
  output line_cmd_t             cmd,
  input  logic                  ready,
  input  logic                  done,
  input  logic [`LINE_BITS-1:0] rdata
);

  typedef enum logic [2:0] {
    IDLE,       // no request.
    WAIT_GRANT, // request seen, bus owned by the other port.
    READ,       // read strobe on the bus.
    READ_WAIT,  // waiting for the line.
    WRITE,      // write strobe with the merged line.
    WRITE_WAIT, // waiting for the store to finish.
    ACK         // ack high until the client drops req.
  } state_t;

  state_t                       state;
  state_t                       state_next;
  logic [`LINE_BITS-1:0]        line_q;    // fetched line, merged for stores.
  logic [`LINE_BITS-1:0]        merged;
  logic [`WORD_OFFSET_BITS-1:0] word_sel;  // word within the line.
  logic [`WORD_BITS-1:0]        word_base; // bit offset of that word.

  assign word_sel  = req_data.addr[`LINE_OFFSET_BITS-1:`WORD_OFFSET_BITS];
  assign word_base = `WORD_BITS'(word_sel) * `WORD_BITS;

  // Store data lands only in the masked bytes of the selected word.
  always_comb begin
    merged = rdata;
    if (req_data.write) begin
      for (int b = 0; b < `WORD_BYTES; b++) begin
        if (req_data.mask[b]) begin
          merged[word_base + 8*b +: 8] = req_data.wdata[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:       if (req) state_next = WAIT_GRANT;
      WAIT_GRANT: if (granted) state_next = READ;
      READ:       state_next = READ_WAIT;
      READ_WAIT:  if (ready) state_next = req_data.write ? WRITE : ACK;
      WRITE:      state_next = WRITE_WAIT;
      WRITE_WAIT: if (done) state_next = ACK;
      ACK:        if (!req) state_next = IDLE; // ack falls one cycle after req.
      default:    state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // The line is captured as it arrives and already holds the merge.
  always_ff @(posedge clock) begin
    if (state == READ_WAIT && ready) begin
      line_q <= merged;
    end
  end

  // A request claims the bus from its rise until the client drops it.
  assign busy = req;

  assign ack       = (state == ACK);
  assign rsp.rdata = line_q[word_base +: `WORD_BITS]; // payload held, so the offset is too.

  assign cmd.read      = (state == READ);
  assign cmd.write     = (state == WRITE);
  assign cmd.line_addr = req_data.addr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS];
  assign cmd.data      = line_q;

  // Four-phase rule seen across the client boundary.
  property p_ack_needs_req;
    @(posedge clock) disable iff (reset)
      $rose(ack) |-> $past(req);
  endproperty

  assert property (p_ack_needs_req)
    else $error("word_port: ack rose without a request");

endmodule

/* verilog/mem_subsystem.sv */
`include "mem_params.svh"

module mem_subsystem
  import mem_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      fetch_req,
  input  word_req_t fetch_req_data,
  output logic      fetch_ack,
  output word_rsp_t fetch_rsp,
  input  logic      data_req,
  input  word_req_t data_req_data,
  output logic      data_ack,
  output word_rsp_t data_rsp
);

  localparam int FETCH = 0; // port index on the arbiter.
  localparam int DATA  = 1;

  logic      [`NUM_PORTS-1:0] busy;
  logic      [`NUM_PORTS-1:0] grant;
  line_cmd_t [`NUM_PORTS-1:0] port_cmd;
  line_cmd_t                  ram_cmd;
  logic                       ram_ready;
  logic                       ram_done;
  logic      [`LINE_BITS-1:0] ram_rdata;

  // instruction fetch side, same ports as the data side.
  word_port fetch_port_i (
    .clock    (clock),
    .reset    (reset),
    .req      (fetch_req),
    .req_data (fetch_req_data),
    .ack      (fetch_ack),
    .rsp      (fetch_rsp),
    .busy     (busy[FETCH]),
    .granted  (grant[FETCH]),
    .cmd      (port_cmd[FETCH]),
    .ready    (ram_ready & grant[FETCH]), // only the owner sees the RAM answer.
    .done     (ram_done & grant[FETCH]),
    .rdata    (ram_rdata)
  );

  word_port data_port_i (
    .clock    (clock),
    .reset    (reset),
    .req      (data_req),
    .req_data (data_req_data),
    .ack      (data_ack),
    .rsp      (data_rsp),
    .busy     (busy[DATA]),
    .granted  (grant[DATA]),
    .cmd      (port_cmd[DATA]),
    .ready    (ram_ready & grant[DATA]),
    .done     (ram_done & grant[DATA]),
    .rdata    (ram_rdata)
  );

  bus_arbiter bus_arbiter_i (
    .clock    (clock),
    .reset    (reset),
    .busy     (busy),
    .port_cmd (port_cmd),
    .grant    (grant),
    .cmd      (ram_cmd)
  );

  line_ram line_ram_i (
    .clock (clock),
    .reset (reset),
    .cmd   (ram_cmd),
    .ready (ram_ready),
    .done  (ram_done),
    .rdata (ram_rdata)
  );

endmodule

/* tests/clock_gen.sv */
module clock_gen (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam time HALF_PERIOD  = 50ns; // 100 ns clock period.
  localparam int  RESET_CYCLES = 3;

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  initial begin
    reset = 1'b1; // held over three rising edges.
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0; // released on a falling edge like every other input.
  end

endmodule

/* tests/mem_checker.sv */
`include "mem_params.svh"

module mem_checker
  import mem_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      fetch_req,
  input  word_req_t fetch_req_data,
  input  logic      fetch_ack,
  input  word_rsp_t fetch_rsp,
  input  logic      data_req,
  input  word_req_t data_req_data,
  input  logic      data_ack,
  input  word_rsp_t data_rsp,
  output int        mismatches,
  output int        protocol_errors,
  output int        fetch_acks,
  output int        data_acks
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] model [`MEM_SIZE_BYTES]; // expected memory contents.
  bit         known [`MEM_SIZE_BYTES]; // set once a byte has been written.
  int         mismatch_count  = 0;
  int         protocol_count  = 0;
  int         fetch_ack_count = 0;
  int         data_ack_count  = 0;
  logic       fetch_ack_q;
  logic       data_ack_q;
  logic       fetch_req_q;
  logic       data_req_q;
  bit         fetch_rose;
  bit         data_rose;

  assign mismatches      = mismatch_count;
  assign protocol_errors = protocol_count;
  assign fetch_acks      = fetch_ack_count;
  assign data_acks       = data_ack_count;

  // Writes update the model and reads are compared against it, in ack order.
  task automatic apply_ack(input string name, input word_req_t rq, input word_rsp_t rs);
    logic [`WORD_BITS-1:0]  expected;
    logic [`ADDR_WIDTH-1:0] a;
    bit                     complete;
    expected = '0;
    complete = 1'b1;
    for (int b = 0; b < `WORD_BYTES; b++) begin
      a = rq.addr + `ADDR_WIDTH'(b);
      if (rq.write && rq.mask[b]) begin
        model[a] = rq.wdata[8*b +: 8];
        known[a] = 1'b1;
      end else if (!rq.write) begin
        complete = complete && known[a];
        expected[8*b +: 8] = model[a];
      end
    end
    if (!rq.write && !complete) begin
      $display("Error: %s read at address %h covers bytes that were never written", name, rq.addr);
      protocol_count++;
    end else if (!rq.write && rs.rdata !== expected) begin
      $display("Mismatch %s_rsp.rdata at address %h: expected %h, got %h",
               name, rq.addr, expected, rs.rdata);
      mismatch_count++;
    end
  endtask

  // One port's handshake as seen on a rising edge.
  // The ack that shows up here rose in the cycle before, so req is judged from then.
  task automatic watch_port(input string name, input logic req_q,
                            input logic ack, input logic ack_q, input word_req_t rq,
                            input word_rsp_t rs, output bit rose);
    rose = (ack === 1'b1) && (ack_q === 1'b0);
    if (rose && req_q !== 1'b1) begin
      $display("Error: %s port raised ack with no request pending", name);
      protocol_count++;
    end
    if (rose) begin
      apply_ack(name, rq, rs);
    end
    if (ack === 1'b0 && ack_q === 1'b1 && req_q === 1'b1) begin
      $display("Error: %s port dropped ack while req was still high", name);
      protocol_count++;
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      fetch_ack_q <= 1'b0;
      data_ack_q  <= 1'b0;
      fetch_req_q <= 1'b0;
      data_req_q  <= 1'b0;
    end else begin
      watch_port("fetch", fetch_req_q, fetch_ack, fetch_ack_q,
                 fetch_req_data, fetch_rsp, fetch_rose);
      watch_port("data", data_req_q, data_ack, data_ack_q,
                 data_req_data, data_rsp, data_rose);
      if (fetch_rose) fetch_ack_count++;
      if (data_rose) data_ack_count++;
      fetch_ack_q <= fetch_ack;
      data_ack_q  <= data_ack;
      fetch_req_q <= fetch_req;
      data_req_q  <= data_req;
    end
  end

endmodule

/* tests/mem_subsystem_tb.sv */
`include "mem_params.svh"

module mem_subsystem_tb
  import mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic FETCH          = 1'b0;
  localparam logic DATA           = 1'b1;
  localparam int   TIMEOUT_CYCLES = 40;

  typedef struct packed {
    logic                   client; // 0 is fetch, 1 is data.
    logic                   write;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`WORD_BITS-1:0]  data;
    logic [`WORD_BYTES-1:0] mask;
    logic                   paired; // starts in the same cycle as the next entry.
  } stim_t;

  logic      clock;
  logic      reset;
  logic      fetch_req;
  word_req_t fetch_req_data;
  logic      fetch_ack;
  word_rsp_t fetch_rsp;
  logic      data_req;
  word_req_t data_req_data;
  logic      data_ack;
  word_rsp_t data_rsp;
  int        mismatches;
  int        protocol_errors;
  int        fetch_acks;
  int        data_acks;
  int        fetch_issued = 0;
  int        data_issued  = 0;
  int        timeouts     = 0;
  stim_t     stim [$];

  clock_gen clock_gen_i (.clock(clock), .reset(reset));

  mem_subsystem mem_subsystem_i (
    .clock          (clock),
    .reset          (reset),
    .fetch_req      (fetch_req),
    .fetch_req_data (fetch_req_data),
    .fetch_ack      (fetch_ack),
    .fetch_rsp      (fetch_rsp),
    .data_req       (data_req),
    .data_req_data  (data_req_data),
    .data_ack       (data_ack),
    .data_rsp       (data_rsp)
  );

  mem_checker mem_checker_i (
    .clock (clock), .reset (reset),
    .fetch_req (fetch_req), .fetch_req_data (fetch_req_data),
    .fetch_ack (fetch_ack), .fetch_rsp (fetch_rsp),
    .data_req (data_req), .data_req_data (data_req_data),
    .data_ack (data_ack), .data_rsp (data_rsp),
    .mismatches (mismatches), .protocol_errors (protocol_errors),
    .fetch_acks (fetch_acks), .data_acks (data_acks)
  );

  function automatic void add_entry(logic client, logic write, logic [`ADDR_WIDTH-1:0] addr,
                                    logic [`WORD_BITS-1:0] data, logic [`WORD_BYTES-1:0] mask,
                                    logic paired);
    stim.push_back('{client, write, addr, data, mask, paired});
  endfunction

  function automatic void build_table();
    add_entry(DATA,  1'b1, 9'h040, 32'h11223344, 4'hf, 1'b0); // full write, then read back.
    add_entry(DATA,  1'b0, 9'h040, '0, '0, 1'b0);
    add_entry(DATA,  1'b1, 9'h050, $urandom(), 4'hf, 1'b0);   // partial masks merge bytes.
    add_entry(DATA,  1'b1, 9'h050, $urandom(), 4'b0101, 1'b0);
    add_entry(DATA,  1'b0, 9'h050, '0, '0, 1'b0);
    add_entry(FETCH, 1'b1, 9'h050, $urandom(), 4'b1000, 1'b0);
    add_entry(DATA,  1'b0, 9'h050, '0, '0, 1'b0);
    add_entry(DATA,  1'b1, 9'h080, 32'haaaa0000, 4'hf, 1'b0); // four words of one line.
    add_entry(FETCH, 1'b1, 9'h084, 32'hbbbb1111, 4'hf, 1'b0);
    add_entry(DATA,  1'b1, 9'h088, 32'hcccc2222, 4'hf, 1'b0);
    add_entry(FETCH, 1'b1, 9'h08c, 32'hdddd3333, 4'hf, 1'b0);
    add_entry(FETCH, 1'b0, 9'h080, '0, '0, 1'b0);
    add_entry(DATA,  1'b0, 9'h084, '0, '0, 1'b0);
    add_entry(FETCH, 1'b0, 9'h088, '0, '0, 1'b0);
    add_entry(DATA,  1'b0, 9'h08c, '0, '0, 1'b0);
    add_entry(DATA,  1'b1, 9'h100, $urandom(), 4'hf, 1'b0);   // data write, fetch read.
    add_entry(FETCH, 1'b0, 9'h100, '0, '0, 1'b0);
    add_entry(FETCH, 1'b1, 9'h0c0, $urandom(), 4'hf, 1'b1);   // both clients on one line.
    add_entry(DATA,  1'b1, 9'h0c4, $urandom(), 4'hf, 1'b0);
    add_entry(FETCH, 1'b1, 9'h0c0, $urandom(), 4'b0011, 1'b1);
    add_entry(DATA,  1'b1, 9'h0c0, $urandom(), 4'b1100, 1'b0);
    add_entry(FETCH, 1'b1, 9'h0c8, $urandom(), 4'hf, 1'b1);
    add_entry(DATA,  1'b1, 9'h0c8, $urandom(), 4'hf, 1'b0);
    add_entry(FETCH, 1'b0, 9'h0c0, '0, '0, 1'b1);
    add_entry(DATA,  1'b0, 9'h0c4, '0, '0, 1'b0);
    add_entry(DATA,  1'b0, 9'h0c8, '0, '0, 1'b1);
    add_entry(FETCH, 1'b1, 9'h040, $urandom(), 4'hf, 1'b0);
    add_entry(DATA,  1'b0, 9'h040, '0, '0, 1'b0);
  endfunction

  function automatic logic ack_of(logic client);
    return (client == DATA) ? data_ack : fetch_ack;
  endfunction

  function automatic string port_name(logic client);
    return (client == DATA) ? "data" : "fetch";
  endfunction

  // One four-phase transfer, each wait bounded by its own timeout.
  task automatic run_request(input stim_t s);
    word_req_t payload;
    int        cycles;
    payload.write = s.write;
    payload.addr  = s.addr;
    payload.wdata = s.data;
    payload.mask  = s.mask;
    @(negedge clock);
    if (s.client == DATA) begin
      data_req_data = payload;
      data_req      = 1'b1;
      data_issued++;
    end else begin
      fetch_req_data = payload;
      fetch_req      = 1'b1;
      fetch_issued++;
    end
    cycles = 0;
    while (ack_of(s.client) !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clock);
      cycles++;
    end
    if (ack_of(s.client) !== 1'b1) begin
      $display("Timeout: %s port gave no ack for address %h", port_name(s.client), s.addr);
      timeouts++;
    end
    if (s.client == DATA) data_req = 1'b0;
    else fetch_req = 1'b0;
    cycles = 0;
    while (ack_of(s.client) !== 1'b0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clock);
      cycles++;
    end
    if (ack_of(s.client) !== 1'b0) begin
      $display("Timeout: %s port kept ack high after req fell", port_name(s.client));
      timeouts++;
    end
  endtask

  initial begin
    int i;
    int cycles;
    int count_errors;
    fetch_req      = 1'b0;
    fetch_req_data = '0;
    data_req       = 1'b0;
    data_req_data  = '0;
    count_errors   = 0;
    void'($urandom(32'hf8ff));
    build_table();
    cycles = 0;
    while (reset !== 1'b0 && cycles < 10) begin
      @(posedge clock);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
    i = 0;
    while (i < stim.size() && timeouts == 0) begin
      if (stim[i].paired && i + 1 < stim.size()) begin
        fork
          run_request(stim[i]);
          run_request(stim[i+1]);
        join
        i += 2;
      end else begin
        run_request(stim[i]);
        i++;
      end
    end
    @(negedge clock);
    if (fetch_acks != fetch_issued || data_acks != data_issued) begin
      $display("Error: %0d fetch and %0d data requests drew %0d and %0d acks",
               fetch_issued, data_issued, fetch_acks, data_acks);
      count_errors = 1;
    end
    $display("Errors: %0d mismatches, %0d protocol, %0d timeouts, %0d ack count",
             mismatches, protocol_errors, timeouts, count_errors);
    if (mismatches + protocol_errors + timeouts + count_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/line_ram.sv
verilog/bus_arbiter.sv
verilog/word_port.sv
verilog/mem_subsystem.sv
tests/clock_gen.sv
tests/mem_checker.sv
tests/mem_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module mem_subsystem_tb \
  -Mdir obj_dir -o mem_sim &&
./obj_dir/mem_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
